// File: src/exec_config.svh
// Decode assumes RV32 so XLEN must stay 32 and ACC_W must be wide enough to hold 32
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// --------------------
// Datapath widths
// --------------------
`define XLEN        32          // Data word width
`define ACC_W       8           // Accuracy value width

// --------------------
// ALU build options
// --------------------
// With approximation off the ALU falls back to a plain adder for R-type ADD
// and the accuracy register has no effect on results.
`define APX_DEFAULT 1           // Default for alu_apx APPROXIMATE

// --------------------
// Reset values
// --------------------
`define ACC_RESET   8'd0        // Zero approximate bits so the adder starts exact

`endif

// File: src/exec_pkg.sv
// Types follow the widths in exec_config.svh and only the five opcodes the stage executes are named
`include "exec_config.svh"

package exec_pkg;

    // --------------------
    // Field types
    // --------------------
    typedef logic [`XLEN-1:0]  word_t;      // pc, rs1, rs2, immediate, result
    typedef logic [6:0]        opcode_t;    // Major opcode
    typedef logic [2:0]        funct3_t;    // Minor function
    typedef logic [6:0]        funct7_t;    // Upper function bits
    typedef logic [`ACC_W-1:0] accuracy_t;  // Approximate low-bit count

    // Accuracy value k means the lowest k sum bits are formed by OR only.
    // Anything above XLEN is treated as XLEN by the adder.

    // --------------------
    // Opcode encodings
    // --------------------
    // Standard RV32 base opcode map, bits [1:0] are always 2'b11
    localparam opcode_t OPC_OP_IMM = 7'b00_100_11;  // Register-immediate ALU ops
    localparam opcode_t OPC_AUIPC  = 7'b00_101_11;  // Add upper immediate to pc
    localparam opcode_t OPC_OP     = 7'b01_100_11;  // Register-register ALU ops
    localparam opcode_t OPC_JALR   = 7'b11_001_11;  // Indirect jump, link value only
    localparam opcode_t OPC_JAL    = 7'b11_011_11;  // Direct jump, link value only

    // Loads, stores, branches, LUI and SYSTEM are not handled by this stage
    // and fall into the illegal path of the ALU.

endpackage

// File: src/approx_adder.sv
// Low part has no carry chain so results differ from exact sums whenever apx_bits is nonzero
`timescale 1ns/10ps
`include "exec_config.svh"

module approx_adder
(
    input  exec_pkg::word_t     a,          // Addend
    input  exec_pkg::word_t     b,          // Addend
    input  exec_pkg::accuracy_t apx_bits,   // Approximate low-bit count
    output exec_pkg::word_t     sum         // Lower-part-OR sum
);
    import exec_pkg::*;

    localparam int SAT_W = $clog2(`XLEN + 1);   // Enough bits for 0..XLEN

    logic [SAT_W-1:0] k_sat;        // Saturated split point
    word_t            low_mask;     // Ones over approximate part
    word_t            low_part;     // OR result of low bits
    word_t            high_part;    // Exact sum of high bits

    // --------------------
    // Split point
    // --------------------
    always_comb
    begin
        if (apx_bits > accuracy_t'(`XLEN))
            k_sat = SAT_W'(`XLEN);      // Clamp at full width
        else
            k_sat = apx_bits[SAT_W-1:0];
    end

    // Shift by XLEN yields zero so the mask becomes all ones
    assign low_mask = ~({`XLEN{1'b1}} << k_sat);

    // --------------------
    // Two halves
    // --------------------
    assign low_part  = (a | b) & low_mask;              // No carry produced
    // Low bits zeroed so nothing carries into the upper part
    assign high_part = (a & ~low_mask) + (b & ~low_mask);

    assign sum = high_part | low_part;  // Halves do not overlap

endmodule

// File: src/operand_select.sv
// Unknown opcodes select rs1 and rs2 and rely on the ALU to flag them illegal
`timescale 1ns/10ps

module operand_select
(
    input  exec_pkg::opcode_t opcode,       // Decoded major opcode
    input  exec_pkg::word_t   pc,           // Instruction address
    input  exec_pkg::word_t   rs1,          // Source register 1 value
    input  exec_pkg::word_t   rs2,          // Source register 2 value
    input  exec_pkg::word_t   immediate,    // Sign-extended immediate
    output exec_pkg::word_t   operand_1,    // ALU input A
    output exec_pkg::word_t   operand_2     // ALU input B
);
    import exec_pkg::*;

    logic       sel_pc;     // Operand 1 takes pc
    logic [1:0] sel_op2;    // 00 rs2, 01 imm, 10 const 4

    // --------------------
    // Select decode
    // --------------------
    always_comb
    begin
        sel_pc  = 1'b0;     // rs1 by default
        sel_op2 = 2'b00;    // rs2 by default
        case (opcode)
            OPC_OP_IMM:
            begin
                sel_op2 = 2'b01;    // Immediate operand
            end
            OPC_JAL,
            OPC_JALR:
            begin
                sel_pc  = 1'b1;     // Link value is pc + 4
                sel_op2 = 2'b10;
            end
            OPC_AUIPC:
            begin
                sel_pc  = 1'b1;
                sel_op2 = 2'b01;    // Upper immediate
            end
            default:
            begin
                sel_pc  = 1'b0;     // OP and unknown opcodes
                sel_op2 = 2'b00;
            end
        endcase
    end

    // --------------------
    // Operand muxes
    // --------------------
    assign operand_1 = sel_pc ? pc : rs1;

    always_comb
    begin
        case (sel_op2)
            2'b01:   operand_2 = immediate;
            2'b10:   operand_2 = word_t'(4);   // Link offset
            default: operand_2 = rs2;
        endcase
    end

endmodule

// File: src/alu_apx.sv
// Only R-type ADD may be approximate and unsupported encodings give zero with illegal high
`timescale 1ns/10ps
`include "exec_config.svh"

module alu_apx
#(
    parameter int APPROXIMATE = `APX_DEFAULT    // 1 routes ADD to approx_adder
)
(
    input  exec_pkg::opcode_t   opcode,     // Major opcode
    input  exec_pkg::funct3_t   funct3,     // Minor function
    input  exec_pkg::funct7_t   funct7,     // Upper function bits
    input  exec_pkg::word_t     operand_1,  // From operand_select
    input  exec_pkg::word_t     operand_2,  // From operand_select
    input  exec_pkg::accuracy_t accuracy,   // Captured with the instruction
    output exec_pkg::word_t     result,     // ALU result
    output logic                illegal     // Encoding not supported
);
    import exec_pkg::*;

    word_t      exact_sum;  // Full carry adder
    word_t      add_sum;    // R-type ADD path
    word_t      diff;       // SUB result
    logic [4:0] shamt;      // Shift amount
    logic       lt_s;       // Signed less-than
    logic       lt_u;       // Unsigned less-than

    assign exact_sum = operand_1 + operand_2;
    assign diff      = operand_1 - operand_2;
    assign shamt     = operand_2[4:0];      // RV32 shifts use 5 bits
    assign lt_s      = $signed(operand_1) < $signed(operand_2);
    assign lt_u      = operand_1 < operand_2;

    // --------------------
    // ADD implementation
    // --------------------
    generate
        if (APPROXIMATE == 1)
        begin : g_apx
            approx_adder u_add
            (
                .a        (operand_1),
                .b        (operand_2),
                .apx_bits (accuracy),   // Runtime accuracy from CSR
                .sum      (add_sum)
            );
        end
        else
        begin : g_exact
            assign add_sum = exact_sum; // Accuracy has no effect
        end
    endgenerate

    // --------------------
    // Operation decode
    // --------------------
    always_comb
    begin
        result  = '0;
        illegal = 1'b0;
        casez ({funct7, funct3, opcode})
            // I-type, funct7 only matters for shifts
            {7'b???????, 3'b000, OPC_OP_IMM}: result = exact_sum;            // ADDI
            {7'b0000000, 3'b001, OPC_OP_IMM}: result = operand_1 << shamt;   // SLLI
            {7'b???????, 3'b010, OPC_OP_IMM}: result = word_t'(lt_s);        // SLTI
            {7'b???????, 3'b011, OPC_OP_IMM}: result = word_t'(lt_u);        // SLTIU
            {7'b???????, 3'b100, OPC_OP_IMM}: result = operand_1 ^ operand_2; // XORI
            {7'b0000000, 3'b101, OPC_OP_IMM}: result = operand_1 >> shamt;   // SRLI
            {7'b0100000, 3'b101, OPC_OP_IMM}:                                // SRAI
                result = word_t'($signed(operand_1) >>> shamt);
            {7'b???????, 3'b110, OPC_OP_IMM}: result = operand_1 | operand_2; // ORI
            {7'b???????, 3'b111, OPC_OP_IMM}: result = operand_1 & operand_2; // ANDI

            // R-type
            {7'b0000000, 3'b000, OPC_OP}:     result = add_sum;              // ADD
            {7'b0100000, 3'b000, OPC_OP}:     result = diff;                 // SUB
            {7'b0000000, 3'b001, OPC_OP}:     result = operand_1 << shamt;   // SLL
            {7'b0000000, 3'b010, OPC_OP}:     result = word_t'(lt_s);        // SLT
            {7'b0000000, 3'b011, OPC_OP}:     result = word_t'(lt_u);        // SLTU
            {7'b0000000, 3'b100, OPC_OP}:     result = operand_1 ^ operand_2; // XOR
            {7'b0000000, 3'b101, OPC_OP}:     result = operand_1 >> shamt;   // SRL
            {7'b0100000, 3'b101, OPC_OP}:                                    // SRA
                result = word_t'($signed(operand_1) >>> shamt);
            {7'b0000000, 3'b110, OPC_OP}:     result = operand_1 | operand_2; // OR
            {7'b0000000, 3'b111, OPC_OP}:     result = operand_1 & operand_2; // AND

            // Jumps and AUIPC always add exactly
            {7'b???????, 3'b???, OPC_JAL}:    result = exact_sum;            // pc + 4
            {7'b???????, 3'b000, OPC_JALR}:   result = exact_sum;            // pc + 4
            {7'b???????, 3'b???, OPC_AUIPC}:  result = exact_sum;            // pc + imm

            default:
            begin
                result  = '0;       // Nothing leaks out
                illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: src/pipe_stage.sv
// One entry only so a full stage passes a new item each cycle only when downstream is ready
`timescale 1ns/10ps

module pipe_stage
#(
    parameter int WIDTH = 32            // Payload width
)
(
    input  logic             clk,
    input  logic             rst_n,     // Sync, active low
    input  logic             in_valid,  // Upstream has data
    output logic             in_ready,  // Stage can accept
    input  logic [WIDTH-1:0] in_data,   // Upstream payload
    output logic             out_valid, // Stage holds data
    input  logic             out_ready, // Downstream can accept
    output logic [WIDTH-1:0] out_data   // Held payload
);

    logic load;     // Transfer into the stage

    // --------------------
    // Handshake
    // --------------------
    // Empty, or draining this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    // --------------------
    // Valid flag
    // --------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            out_valid <= 1'b0;      // Stage empty after reset
        else if (in_ready)
            out_valid <= in_valid;  // Fill, refill or drain
    end

    // --------------------
    // Payload
    // --------------------
    always_ff @(posedge clk)
    begin
        if (load)
            out_data <= in_data;    // Held while stalled
    end

endmodule

// File: src/exec_top.sv
// Accuracy is sampled per instruction at acceptance so a CSR write on that edge applies later
`timescale 1ns/10ps
`include "exec_config.svh"

module exec_top
(
    input  logic                clk,
    input  logic                rst_n,          // Sync, active low
    input  logic                csr_we,         // Accuracy write strobe
    input  exec_pkg::accuracy_t csr_wdata,      // New accuracy value
    input  logic                in_valid,       // Instruction present
    output logic                in_ready,       // Stage can accept
    input  exec_pkg::opcode_t   opcode,
    input  exec_pkg::funct3_t   funct3,
    input  exec_pkg::funct7_t   funct7,
    input  exec_pkg::word_t     pc,
    input  exec_pkg::word_t     rs1,
    input  exec_pkg::word_t     rs2,
    input  exec_pkg::word_t     immediate,
    output logic                out_valid,      // Result present
    input  logic                out_ready,      // Sink can accept
    output exec_pkg::word_t     out_result,
    output logic                out_illegal     // Unsupported encoding
);
    import exec_pkg::*;

    localparam int IN_W  = $bits(opcode_t) + $bits(funct3_t) + $bits(funct7_t)
                         + 4 * $bits(word_t) + $bits(accuracy_t);
    localparam int OUT_W = $bits(word_t) + 1;   // Result plus illegal flag

    accuracy_t        acc_q;        // Accuracy CSR
    logic [IN_W-1:0]  in_data;      // Packed instruction
    logic [IN_W-1:0]  s1_data;      // Held instruction
    logic             s1_valid;
    logic             s1_ready;     // Output stage can take
    opcode_t          s1_opcode;
    funct3_t          s1_funct3;
    funct7_t          s1_funct7;
    word_t            s1_pc;
    word_t            s1_rs1;
    word_t            s1_rs2;
    word_t            s1_imm;
    accuracy_t        s1_acc;       // Accuracy for this instruction
    word_t            op_a;
    word_t            op_b;
    word_t            alu_result;
    logic             alu_illegal;
    logic [OUT_W-1:0] out_data;

    // --------------------
    // Accuracy register
    // --------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            acc_q <= `ACC_RESET;
        else if (csr_we)
            acc_q <= csr_wdata;
    end

    // --------------------
    // Input stage
    // --------------------
    assign in_data = {opcode, funct3, funct7, pc, rs1, rs2, immediate, acc_q};

    pipe_stage #(.WIDTH(IN_W)) u_in_stage
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (s1_valid),
        .out_ready (s1_ready),
        .out_data  (s1_data)
    );

    assign {s1_opcode, s1_funct3, s1_funct7, s1_pc, s1_rs1, s1_rs2, s1_imm, s1_acc} = s1_data;

    // --------------------
    // Execute
    // --------------------
    operand_select u_opsel
    (
        .opcode    (s1_opcode),
        .pc        (s1_pc),
        .rs1       (s1_rs1),
        .rs2       (s1_rs2),
        .immediate (s1_imm),
        .operand_1 (op_a),
        .operand_2 (op_b)
    );

    alu_apx #(.APPROXIMATE(`APX_DEFAULT)) u_alu
    (
        .opcode    (s1_opcode),
        .funct3    (s1_funct3),
        .funct7    (s1_funct7),
        .operand_1 (op_a),
        .operand_2 (op_b),
        .accuracy  (s1_acc),
        .result    (alu_result),
        .illegal   (alu_illegal)
    );

    // --------------------
    // Output stage
    // --------------------
    pipe_stage #(.WIDTH(OUT_W)) u_out_stage
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (s1_valid),
        .in_ready  (s1_ready),
        .in_data   ({alu_result, alu_illegal}),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    assign {out_result, out_illegal} = out_data;

endmodule

// File: tests/tb_clock.sv
// Free-running 40 ns clock and a synchronous active-low reset held for the first 4 rising edges
`timescale 1ns/10ps

module tb_clock
(
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk   = 1'b0;
        rst_n = 1'b0;               // Reset from time zero
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;              // Released on the 4th edge
    end

    always #20 clk = ~clk;          // 40 ns period

endmodule

// File: tests/exec_sva.sv
// Checks only the top-level handshakes and the reset state and needs the internal acc_q bound in
`timescale 1ns/10ps
`include "exec_config.svh"

module exec_sva
(
    input logic                clk,
    input logic                rst_n,
    input logic                in_ready,
    input logic                out_valid,
    input logic                out_ready,
    input exec_pkg::word_t     out_result,
    input logic                out_illegal,
    input exec_pkg::accuracy_t acc_q        // Accuracy register inside exec_top
);
    import exec_pkg::*;

    // --------------------
    // Output stall
    // --------------------
    // Held result must not move until the sink takes it
    property p_stall_stable;
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_result) && $stable(out_illegal));
    endproperty

    a_stall_stable: assert property (p_stall_stable)
        else $error("output changed or dropped during a stall");

    // Empty output stage means the input side has room
    a_ready_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> in_ready)
        else $error("in_ready low while the output stage is empty");

    // --------------------
    // Reset state
    // --------------------
    a_reset_out_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    a_reset_in_ready: assert property (@(posedge clk) !rst_n |=> in_ready)
        else $error("in_ready low in the cycle after reset");

    a_reset_acc: assert property (@(posedge clk) !rst_n |=> (acc_q == `ACC_RESET))
        else $error("accuracy register not at its reset value");

endmodule

bind exec_top exec_sva u_sva
(
    .clk         (clk),
    .rst_n       (rst_n),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_result  (out_result),
    .out_illegal (out_illegal),
    .acc_q       (acc_q)
);

// File: tests/exec_tb.sv
// Accuracy changes only while in_valid is low so the model can track the CSR value at acceptance
`timescale 1ns/10ps
`include "exec_config.svh"

module exec_tb;
    import exec_pkg::*;

    localparam int N_INSTR = 1 + 76 + 9 + 30 + 4 + 60;     // All tests together
    localparam int LIMIT   = 4 * N_INSTR + 200;            // Timeout in cycles

    logic clk, rst_n, csr_we, in_valid, in_ready, out_valid, out_ready, out_illegal;
    accuracy_t csr_wdata;
    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    word_t     pc, rs1, rs2, immediate, out_result;

    logic [32:0] exp_q[$];          // {illegal, result} per accepted instruction
    accuracy_t   acc_shadow;        // Model copy of the CSR
    logic [31:0] stim_seed, rdy_seed;
    logic        bp_on;             // Random out_ready enable
    int          errors, checks, cycles;

    tb_clock u_clk (.clk(clk), .rst_n(rst_n));

    exec_top uut
    (
        .clk(clk), .rst_n(rst_n), .csr_we(csr_we), .csr_wdata(csr_wdata),
        .in_valid(in_valid), .in_ready(in_ready), .opcode(opcode), .funct3(funct3),
        .funct7(funct7), .pc(pc), .rs1(rs1), .rs2(rs2), .immediate(immediate),
        .out_valid(out_valid), .out_ready(out_ready), .out_result(out_result),
        .out_illegal(out_illegal)
    );

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    // --------------------
    // Reference model
    // --------------------
    // Low k bits by OR and the carry chain starts at bit k from zero
    function automatic word_t lower_or_add(word_t a, word_t b, accuracy_t acc);
        int   k;
        logic c;
        word_t s;
        k = (acc > 32) ? 32 : int'(acc);
        c = 1'b0;
        for (int i = 0; i < 32; i++)
        begin
            if (i < k)
                s[i] = a[i] | b[i];
            else
                {c, s[i]} = a[i] + b[i] + c;
        end
        return s;
    endfunction

    function automatic word_t shift_arith(word_t a, logic [4:0] sh);
        return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
    endfunction

    function automatic logic [32:0] model(opcode_t op, funct3_t f3, funct7_t f7, word_t pcv,
                                          word_t r1, word_t r2, word_t imm, accuracy_t acc);
        word_t a, b, r;
        logic  ill, lts, jmp;
        jmp = (op == OPC_JAL) || (op == OPC_JALR);
        a   = (jmp || op == OPC_AUIPC) ? pcv : r1;
        b   = (op == OPC_OP_IMM || op == OPC_AUIPC) ? imm : (jmp ? 32'd4 : r2);
        lts = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);     // Signed via bias
        r   = '0;
        ill = 1'b0;
        if (op == OPC_OP_IMM || (op == OPC_OP && (f7 == 7'h00 || f7 == 7'h20)))
        begin
            case (f3)
                3'd0: r = (op == OPC_OP_IMM) ? a + b
                        : (f7 == 7'h20 ? a - b : lower_or_add(a, b, acc));
                3'd1: r = a << b[4:0];
                3'd2: r = {31'b0, lts};
                3'd3: r = {31'b0, a < b};
                3'd4: r = a ^ b;
                3'd5: r = (f7 == 7'h20) ? shift_arith(a, b[4:0]) : a >> b[4:0];
                3'd6: r = a | b;
                default: r = a & b;
            endcase
            // SUB and SRA are the only funct7 0100000 forms and SLLI needs funct7 zero
            if (op == OPC_OP && f7 == 7'h20 && f3 != 3'd0 && f3 != 3'd5)
                ill = 1'b1;
            if (op == OPC_OP_IMM && ((f3 == 3'd1 && f7 != 7'h00)
                || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)))
                ill = 1'b1;
        end
        else if (op == OPC_JAL || op == OPC_AUIPC || (op == OPC_JALR && f3 == 3'd0))
            r = a + b;
        else
            ill = 1'b1;
        if (ill)
            r = '0;
        return {ill, r};
    endfunction

    // --------------------
    // Scoreboard
    // --------------------
    always @(posedge clk)
    begin : scoreboard
        logic [32:0] exp;
        if (rst_n && out_valid && out_ready)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Output transfer at %0t with no instruction pending", $time);
                errors++;
            end
            else
            begin
                exp = exp_q.pop_front();
                checks++;
                assert (out_result === exp[31:0])
                else
                begin
                    $display("FAILED %0t out_result expected %h actual %h",
                             $time, exp[31:0], out_result);
                    errors++;
                end
                assert (out_illegal === exp[32])
                else
                begin
                    $display("FAILED %0t out_illegal expected %b actual %b",
                             $time, exp[32], out_illegal);
                    errors++;
                end
            end
        end
        if (rst_n && in_valid && in_ready)
            exp_q.push_back(model(opcode, funct3, funct7, pc, rs1, rs2, immediate, acc_shadow));
    end

    always @(posedge clk)
    begin
        rdy_seed = xorshift(rdy_seed);
        out_ready <= bp_on ? rdy_seed[7] : 1'b1;    // Sink stalls at random
        cycles++;
        if (cycles > LIMIT)
        begin
            $display("Timeout after %0d cycles with %0d results pending", cycles, exp_q.size());
            $display("Test FAILED");
            $finish;
        end
    end

    // --------------------
    // Driver tasks
    // --------------------
    task automatic issue(opcode_t op, funct3_t f3, funct7_t f7, word_t p, word_t a, word_t b,
                         word_t imm);
        in_valid  <= 1'b1;
        opcode    <= op;
        funct3    <= f3;
        funct7    <= f7;
        pc        <= p;
        rs1       <= a;
        rs2       <= b;
        immediate <= imm;
        do
            @(posedge clk);
        while (!in_ready);      // Held until accepted
    endtask

    task automatic issue_rand(opcode_t op, funct3_t f3, funct7_t f7);
        word_t v[4];
        for (int i = 0; i < 4; i++)
        begin
            stim_seed = xorshift(stim_seed);
            v[i] = stim_seed;
        end
        issue(op, f3, f7, v[0] & ~32'h3, v[1], v[2], v[3]);
    endtask

    task automatic write_acc(accuracy_t v);
        in_valid  <= 1'b0;
        csr_we    <= 1'b1;
        csr_wdata <= v;
        @(posedge clk);
        acc_shadow = v;         // Taken on this edge
        csr_we <= 1'b0;
    endtask

    task automatic finish_test(string name, int err0, int chk0);
        in_valid <= 1'b0;
        @(posedge clk);
        while (exp_q.size() != 0)
            @(posedge clk);
        @(posedge clk);
        $display("%-12s checks %0d errors %0d", name, checks - chk0, errors - err0);
    endtask

    // --------------------
    // Tests
    // --------------------
    initial
    begin : tests
        int        e0, c0;
        accuracy_t accs[5];
        accs       = '{8'd0, 8'd4, 8'd16, 8'd32, 8'd200};
        csr_we     = 1'b0;
        csr_wdata  = '0;
        in_valid   = 1'b0;
        out_ready  = 1'b1;
        bp_on      = 1'b0;
        opcode     = '0;
        funct3     = '0;
        funct7     = '0;
        pc         = '0;
        rs1        = '0;
        rs2        = '0;
        immediate  = '0;
        stim_seed  = 88;
        rdy_seed   = 88;
        acc_shadow = `ACC_RESET;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        wait (rst_n);
        @(posedge clk);

        e0 = errors;                        // First ADD with no CSR write
        c0 = checks;
        issue(OPC_OP, 3'd0, 7'h00, 0, 32'h0000_ffff, 32'h0000_0001, 0);
        finish_test("reset", e0, c0);

        e0 = errors;
        c0 = checks;
        for (int rep = 0; rep < 4; rep++)
        begin
            for (int f = 0; f < 8; f++)
            begin
                issue_rand(OPC_OP_IMM, funct3_t'(f), 7'h00);
                issue_rand(OPC_OP, funct3_t'(f), 7'h00);
            end
            issue_rand(OPC_OP_IMM, 3'd5, 7'h20);    // SRAI
            issue_rand(OPC_OP, 3'd0, 7'h20);        // SUB
            issue_rand(OPC_OP, 3'd5, 7'h20);        // SRA
        end
        finish_test("alu_ops", e0, c0);

        e0 = errors;
        c0 = checks;
        for (int i = 0; i < 3; i++)
        begin
            write_acc(accs[2 * i]);
            issue_rand(OPC_JAL, 3'd3, 7'h00);
            issue_rand(OPC_JALR, 3'd0, 7'h00);
            issue_rand(OPC_AUIPC, 3'd0, 7'h00);
        end
        finish_test("jumps", e0, c0);

        e0 = errors;
        c0 = checks;
        for (int i = 0; i < 5; i++)
        begin
            write_acc(accs[i]);
            repeat (5) issue_rand(OPC_OP, 3'd0, 7'h00);
            issue_rand(OPC_OP_IMM, 3'd0, 7'h00);
        end
        finish_test("approx_add", e0, c0);

        e0 = errors;
        c0 = checks;
        issue_rand(7'b0000011, 3'd2, 7'h00);        // LOAD
        issue_rand(OPC_OP, 3'd0, 7'h01);            // MUL encoding
        issue_rand(OPC_JALR, 3'd1, 7'h00);
        issue_rand(OPC_OP_IMM, 3'd1, 7'h20);
        finish_test("illegal", e0, c0);

        e0 = errors;
        c0 = checks;
        write_acc(8'd8);
        bp_on = 1'b1;
        for (int i = 0; i < 60; i++)
        begin
            stim_seed = xorshift(stim_seed);
            issue_rand(stim_seed[0] ? OPC_OP : OPC_OP_IMM, stim_seed[3:1],
                       (stim_seed[6:4] == 3'd0) ? 7'h20 : 7'h00);
        end
        finish_test("backpressure", e0, c0);
        bp_on = 1'b0;

        $display("Total checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+src
src/exec_pkg.sv
src/approx_adder.sv
src/operand_select.sv
src/alu_apx.sv
src/pipe_stage.sv
src/exec_top.sv
tests/tb_clock.sv
tests/exec_sva.sv
tests/exec_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; exit status is nonzero on failure

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module exec_tb -f tb.f -o exec_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/exec_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0
